//--- verilog.f
+incdir+include
rtl/fx3_bus_pkg.sv
rtl/fx3_ctrl_pkg.sv
rtl/fifo_sync_fwft.sv
rtl/fx3_slave_fifo_ctrl.sv
rtl/fx3_bridge_top.sv
bench/tb_clock.sv
bench/fx3_bridge_checker.sv
bench/fx3_bridge_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FX3 bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fx3_bridge_tb \
   -f verilog.f -o fx3_sim

./obj_dir/fx3_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Regression passed$" sim.log; then
   exit 0
else
   exit 1
fi

//--- bench/fx3_bridge_tb.sv
`timescale 1ns/100ps
`include "fx3_consts.svh"

module fx3_bridge_tb
   import fx3_bus_pkg::*;
();

   localparam int WORDS = 200;
   // Words the in-endpoint holds before it reports full
   localparam int IN_CAP = 6;
   localparam longint WATCH_CYCLES = 2 * WORDS * 40 + `FX3_FLUSH_TIMEOUT * 4;

   logic clk_io_100, int_rst, fx3_com_rst, fx3_logic_rst;
   logic [`FX3_WIDTH-1:0] dq_in, dq_out, fifo_out_data, fifo_in_data;
   logic dq_oe, sloe_n, slrd_n, slwr_n, pktend_n;
   logic flaga_n, flagb_n, flagc_n, flagd_n;
   logic fifo_out_valid, fifo_out_ready, fifo_in_valid, fifo_in_ready;
   logic com_rst, ctrl_logic_rst;
   fx3_ep_e fx3_a;

   logic [15:0] lfsr = 16'd61227;
   logic [`FX3_WIDTH-1:0] h2f[$], f2h[$], eg_exp[$], ing_exp[$];
   logic [`FX3_WIDTH-1:0] rd_word [4];
   logic rd_vld [4];
   int in_level = 0, stall_cnt = 0, pktend_cnt = 0, eg_left = 0, ing_got = 0;
   logic stall_en = 1'b0, rdy_en = 1'b0, take = 1'b0;

   tb_clock #(.PERIOD(40)) u_clock (.clk_io_100(clk_io_100));

   fx3_bridge_top dut (.*);

   // 16-bit Fibonacci LFSR, one step per bit taken
   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] v;
      logic fb;
      int i;
      v = '0;
      for (i = 0; i < n; i++) begin
         fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         v = {v[14:0], fb};
      end
      return v;
   endfunction

   task automatic fail_run(input string why);
      $display("%s at %0t", why, $time);
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic compare_word(input logic [`FX3_WIDTH-1:0] act, exp, input string what);
      if (act !== exp) begin
         $display("mismatch at %0t: %s got %h expected %h", $time, what, act, exp);
         fail_run("data check failed");
      end
   endtask

   task automatic compare_ep(input fx3_ep_e act, exp, input string what);
      if (act !== exp) begin
         $display("mismatch at %0t: %s got %s expected %s", $time, what, act.name(), exp.name());
         fail_run("address check failed");
      end
   endtask

   task automatic compare_bit(input logic act, exp, input string what);
      if (act !== exp) begin
         $display("mismatch at %0t: %s got %b expected %b", $time, what, act, exp);
         fail_run("signal check failed");
      end
   endtask

   // FX3 device model and user side drivers
   always begin
      @(negedge clk_io_100);
      if (stall_cnt != 0) begin
         stall_cnt--;
      end else begin
         if (stall_en && rand_bits(3) == 0)
            stall_cnt = 4 + int'(rand_bits(5));
         if (in_level != 0)
            in_level--;
      end
      flaga_n = (in_level < IN_CAP);
      flagb_n = (in_level < IN_CAP - 2);
      for (int i = 3; i > 0; i--) begin
         rd_vld[i]  = rd_vld[i-1];
         rd_word[i] = rd_word[i-1];
      end
      rd_vld[0] = 1'b0;
      dq_in = rd_word[3];
      // Out-endpoint stays non-empty while read words are in flight
      flagc_n = (h2f.size() != 0) || rd_vld[1] || rd_vld[2] || rd_vld[3];
      flagd_n = (h2f.size() > 3);
      if (!fifo_out_valid || take) begin
         take = 1'b0;
         fifo_out_valid = (eg_left > 0) && (rand_bits(2) != 0);
         fifo_out_data = rand_bits(16);
      end
      fifo_in_ready = rdy_en && (rand_bits(2) != 0);

      #10;
      if (!slwr_n) begin
         compare_ep(fx3_a, FX3_EP_IN, "write address");
         compare_bit(dq_oe, 1'b1, "dq_oe on write");
         compare_bit(flaga_n, 1'b1, "write while in-full");
         if (eg_exp.size() == 0)
            fail_run("write strobe with no egress word pending");
         f2h.push_back(dq_out);
         compare_word(f2h[$], eg_exp.pop_front(), "egress word");
         in_level++;
         if (in_level > IN_CAP)
            fail_run("in-endpoint overflowed");
      end
      if (!slrd_n) begin
         compare_ep(fx3_a, FX3_EP_OUT, "read address");
         if (h2f.size() == 0)
            fail_run("read strobe on an empty out-endpoint");
         rd_vld[0]  = 1'b1;
         rd_word[0] = h2f.pop_front();
      end
      if (!pktend_n)
         pktend_cnt++;
      if (fifo_out_valid && fifo_out_ready) begin
         eg_exp.push_back(fifo_out_data);
         eg_left--;
         take = 1'b1;
      end
      if (fifo_in_valid && fifo_in_ready) begin
         if (ing_exp.size() == 0)
            fail_run("ingress word delivered that the host never sent");
         compare_word(fifo_in_data, ing_exp.pop_front(), "ingress word");
         ing_got++;
      end
   end

   initial begin
      #(WATCH_CYCLES * 40);
      $display("watchdog expired before the tests finished");
      $display("Regression failed");
      $fatal(1);
   end

   initial begin
      int n;
      int_rst = 1'b1;
      fx3_com_rst = 1'b0;
      fx3_logic_rst = 1'b0;
      dq_in = '0;
      flaga_n = 1'b1;
      flagb_n = 1'b1;
      flagc_n = 1'b0;
      flagd_n = 1'b0;
      fifo_out_valid = 1'b0;
      fifo_out_data = '0;
      fifo_in_ready = 1'b0;
      for (int i = 0; i < 4; i++) begin
         rd_vld[i]  = 1'b0;
         rd_word[i] = '0;
      end
      // Host words for the ingress test, drawn before the model starts
      for (int i = 0; i < WORDS; i++)
         ing_exp.push_back(rand_bits(16));
      repeat (5) @(posedge clk_io_100);
      @(negedge clk_io_100);
      int_rst = 1'b0;

      // State right after reset and the zero-length packet
      #10;
      compare_bit(sloe_n & slrd_n & slwr_n & pktend_n, 1'b1, "strobes after reset");
      compare_bit(fifo_in_valid, 1'b0, "fifo_in_valid after reset");
      compare_bit(fifo_out_ready, 1'b1, "fifo_out_ready after reset");
      n = 0;
      while (pktend_cnt == 0 && n < 20) begin
         @(posedge clk_io_100);
         n++;
      end
      if (pktend_cnt != 1)
         fail_run("expected exactly one pktend after reset");

      // Egress with host stalls on the in-endpoint
      stall_en = 1'b1;
      eg_left = WORDS;
      while (f2h.size() < WORDS)
         @(posedge clk_io_100);
      stall_en = 1'b0;
      stall_cnt = 0;
      n = pktend_cnt;
      for (int i = 0; i < `FX3_FLUSH_TIMEOUT + 8 && pktend_cnt == n; i++)
         @(posedge clk_io_100);
      if (pktend_cnt == n)
         fail_run("no pktend after the last egress word");

      // Ingress under random back-pressure
      for (int i = 0; i < WORDS; i++)
         h2f.push_back(ing_exp[i]);
      rdy_en = 1'b1;
      while (ing_got < WORDS)
         @(posedge clk_io_100);

      // Host side resets
      rdy_en = 1'b0;
      for (int i = 0; i < 4; i++)
         h2f.push_back(`FX3_WIDTH'(i));
      @(negedge clk_io_100);
      while (!fifo_in_valid)
         @(negedge clk_io_100);
      @(negedge clk_io_100);
      fx3_com_rst = 1'b1;
      #10;
      compare_bit(com_rst, 1'b1, "com_rst");
      compare_bit(fifo_in_valid, 1'b0, "fifo_in_valid in link reset");
      @(negedge clk_io_100);
      fx3_com_rst = 1'b0;
      fx3_logic_rst = 1'b1;
      #10;
      compare_bit(ctrl_logic_rst, 1'b1, "ctrl_logic_rst high");
      compare_bit(com_rst, 1'b0, "com_rst released");
      @(negedge clk_io_100);
      fx3_logic_rst = 1'b0;
      #10;
      compare_bit(ctrl_logic_rst, 1'b0, "ctrl_logic_rst low");
      repeat (4) @(negedge clk_io_100);
      $display("Regression passed");
      $finish;
   end

endmodule

//--- bench/fx3_bridge_checker.sv
`timescale 1ns/100ps

module fx3_bridge_checker
   import fx3_ctrl_pkg::*;
(
   input logic       clk_io_100,
   input logic       int_rst,
   input logic       sloe_n,
   input logic       slrd_n,
   input logic       slwr_n,
   input logic       pktend_n,
   input logic       flaga_n,
   input fx3_state_e state
);

   // Read and write never share a cycle
   a_rd_wr_excl: assert property (@(posedge clk_io_100) !(!slrd_n && !slwr_n))
      else $error("slrd_n and slwr_n both low");

   a_oe_with_rd: assert property (@(posedge clk_io_100) !slrd_n |-> !sloe_n)
      else $error("slrd_n low without sloe_n");

   // Zero-length packet only into a non-full endpoint
   a_pktend_not_full: assert property (@(posedge clk_io_100) !pktend_n |-> flaga_n)
      else $error("pktend_n low while in-endpoint full");

   a_reset_quiet: assert property (@(posedge clk_io_100)
      int_rst |-> (sloe_n && slrd_n && slwr_n && pktend_n && state == STATE_IDLE))
      else $error("strobes active during reset");

endmodule

bind fx3_slave_fifo_ctrl fx3_bridge_checker u_checker (
   .clk_io_100 (clk_io_100),
   .int_rst    (int_rst),
   .sloe_n     (sloe_n),
   .slrd_n     (slrd_n),
   .slwr_n     (slwr_n),
   .pktend_n   (pktend_n),
   .flaga_n    (flaga_n),
   .state      (state)
);

//--- bench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
   parameter int PERIOD = 40
) (
   output logic clk_io_100
);

   initial clk_io_100 = 1'b0;

   always #(PERIOD / 2) clk_io_100 = ~clk_io_100;

endmodule

//--- rtl/fx3_bridge_top.sv
`timescale 1ns/100ps
`include "fx3_consts.svh"

module fx3_bridge_top
   import fx3_bus_pkg::*;
(
   input  logic                  clk_io_100,
   input  logic                  int_rst,
   // FX3 slave FIFO pins
   input  logic [`FX3_WIDTH-1:0] dq_in,
   output logic [`FX3_WIDTH-1:0] dq_out,
   output logic                  dq_oe,
   output fx3_ep_e               fx3_a,
   output logic                  sloe_n,
   output logic                  slrd_n,
   output logic                  slwr_n,
   output logic                  pktend_n,
   input  logic                  flaga_n,
   input  logic                  flagb_n,
   input  logic                  flagc_n,
   input  logic                  flagd_n,
   input  logic                  fx3_com_rst,
   input  logic                  fx3_logic_rst,
   // User side egress stream
   input  logic                  fifo_out_valid,
   output logic                  fifo_out_ready,
   input  logic [`FX3_WIDTH-1:0] fifo_out_data,
   // User side ingress stream
   output logic                  fifo_in_valid,
   input  logic                  fifo_in_ready,
   output logic [`FX3_WIDTH-1:0] fifo_in_data,
   output logic                  com_rst,
   output logic                  ctrl_logic_rst
);

   logic link_rst;
   logic egress_full, egress_empty, egress_pop;
   logic ingress_empty, ingress_almost_full, ingress_push;

   // Host can reset the link through the FX3
   assign link_rst       = int_rst | fx3_com_rst;
   assign com_rst        = link_rst;
   assign ctrl_logic_rst = fx3_logic_rst;

   // FPGA drives the bus only while addressing the in-endpoint
   assign dq_oe = (fx3_a == FX3_EP_IN);

   assign fifo_out_ready = ~egress_full;
   assign fifo_in_valid  = ~ingress_empty;

   fifo_sync_fwft #(.DEPTH(`FX3_BUFFER_DEPTH), .AF_MARGIN(0)) u_egress_buf (
      .clk_io_100  (clk_io_100),
      .int_rst     (link_rst),
      .din         (fifo_out_data),
      .wr_en       (fifo_out_valid),
      .rd_en       (egress_pop),
      .dout        (dq_out),
      .full        (egress_full),
      .empty       (egress_empty),
      .almost_full ()
   );

   fifo_sync_fwft #(
      .DEPTH     (`FX3_BUFFER_DEPTH),
      .AF_MARGIN (`FX3_INGRESS_MARGIN)
   ) u_ingress_buf (
      .clk_io_100  (clk_io_100),
      .int_rst     (link_rst),
      .din         (dq_in),
      .wr_en       (ingress_push),
      .rd_en       (fifo_in_ready),
      .dout        (fifo_in_data),
      .full        (),
      .empty       (ingress_empty),
      .almost_full (ingress_almost_full)
   );

   fx3_slave_fifo_ctrl u_ctrl (
      .clk_io_100          (clk_io_100),
      .int_rst             (link_rst),
      .flaga_n             (flaga_n),
      .flagb_n             (flagb_n),
      .flagc_n             (flagc_n),
      .flagd_n             (flagd_n),
      .egress_empty        (egress_empty),
      .ingress_almost_full (ingress_almost_full),
      .egress_pop          (egress_pop),
      .ingress_push        (ingress_push),
      .fx3_a               (fx3_a),
      .sloe_n              (sloe_n),
      .slrd_n              (slrd_n),
      .slwr_n              (slwr_n),
      .pktend_n            (pktend_n)
   );

endmodule

//--- rtl/fx3_slave_fifo_ctrl.sv
`timescale 1ns/100ps
`include "fx3_consts.svh"

module fx3_slave_fifo_ctrl
   import fx3_bus_pkg::*;
   import fx3_ctrl_pkg::*;
(
   input  logic    clk_io_100,
   input  logic    int_rst,
   input  logic    flaga_n,
   input  logic    flagb_n,
   input  logic    flagc_n,
   input  logic    flagd_n,
   input  logic    egress_empty,
   input  logic    ingress_almost_full,
   output logic    egress_pop,
   output logic    ingress_push,
   output fx3_ep_e fx3_a,
   output logic    sloe_n,
   output logic    slrd_n,
   output logic    slwr_n,
   output logic    pktend_n
);

   localparam int IW = $clog2(`FX3_FLUSH_TIMEOUT + 1);
   localparam int SW = $clog2(`FX3_SWRW_WAIT + 1);

   fx3_state_e    state, nxt_state;
   logic [IW-1:0] idle_cnt, nxt_idle_cnt;
   logic [SW-1:0] swrw_cnt, nxt_swrw_cnt;
   logic          flush, nxt_flush;
   logic [1:0]    rd_delay;
   logic          rd_valid;
   logic          oe, rd, wr, pktend;
   logic          in_full, in_almost_full, out_empty, out_almost_empty;

   assign in_full          = ~flaga_n;
   assign in_almost_full   = ~flagb_n;
   assign out_empty        = ~flagc_n;
   assign out_almost_empty = ~flagd_n;

   always_ff @(posedge clk_io_100 or posedge int_rst) begin
      if (int_rst) begin
         state    <= STATE_IDLE;
         idle_cnt <= '0;
         swrw_cnt <= '0;
         // One zero-length packet follows every reset
         flush    <= 1'b1;
         rd_delay <= '0;
         rd_valid <= 1'b0;
      end else begin
         state    <= nxt_state;
         idle_cnt <= nxt_idle_cnt;
         swrw_cnt <= nxt_swrw_cnt;
         flush    <= nxt_flush;
         // Device presents read data three cycles after slrd_n
         rd_delay <= {rd_delay[0], rd};
         rd_valid <= rd_delay[1];
      end
   end

   always_comb begin
      nxt_state    = state;
      nxt_idle_cnt = (idle_cnt != '0) ? idle_cnt - IW'(1) : '0;
      nxt_swrw_cnt = (swrw_cnt != '0) ? swrw_cnt - SW'(1) : '0;
      nxt_flush    = flush | (idle_cnt == IW'(1));
      oe           = 1'b0;
      rd           = 1'b0;
      wr           = 1'b0;
      pktend       = 1'b0;
      fx3_a        = FX3_EP_IN;

      case (state)
         STATE_IDLE: begin
            // Write first, then flush, then read
            if (!in_full && !egress_empty)
               nxt_state = STATE_FLG_A_RCVD;
            else if (flush)
               nxt_state = STATE_WRITE_FLUSH;
            else if (!out_empty && !ingress_almost_full)
               nxt_state = STATE_FLG_C_RCVD;
         end
         STATE_FLG_A_RCVD: begin
            nxt_idle_cnt = '0;
            nxt_flush    = 1'b0;
            nxt_swrw_cnt = SW'(`FX3_SWRW_WAIT);
            nxt_state    = STATE_WAIT_FLG_B;
         end
         STATE_WAIT_FLG_B: begin
            if (in_full) begin
               nxt_idle_cnt = IW'(`FX3_FLUSH_TIMEOUT);
               nxt_state    = STATE_IDLE;
            end else if (!in_almost_full) begin
               nxt_state = STATE_WRITE;
            end else if (swrw_cnt == SW'(1)) begin
               nxt_state = STATE_SW_WRITE;
            end
         end
         STATE_WRITE: begin
            if (egress_empty || in_almost_full) begin
               nxt_idle_cnt = IW'(`FX3_FLUSH_TIMEOUT);
               nxt_state    = STATE_IDLE;
            end else begin
               wr = 1'b1;
            end
         end
         STATE_SW_WRITE: begin
            wr           = 1'b1;
            nxt_swrw_cnt = SW'(3);
            nxt_state    = STATE_SW_WRITE_WAITFLG;
         end
         STATE_SW_WRITE_WAITFLG: begin
            // Give the flags time to settle after the lone word
            if (swrw_cnt == SW'(1)) begin
               nxt_idle_cnt = IW'(`FX3_FLUSH_TIMEOUT);
               nxt_state    = STATE_IDLE;
            end
         end
         STATE_WRITE_FLUSH: begin
            nxt_flush = 1'b0;
            if (!in_full) begin
               pktend       = 1'b1;
               nxt_swrw_cnt = SW'(`FX3_SWRW_WAIT);
               nxt_state    = STATE_WAIT_FLG_A;
            end else begin
               nxt_state = STATE_IDLE;
            end
         end
         STATE_WAIT_FLG_A: begin
            // Device briefly reports full while it commits the packet
            if (in_full || swrw_cnt == SW'(1))
               nxt_state = STATE_IDLE;
         end
         STATE_FLG_C_RCVD: begin
            fx3_a        = FX3_EP_OUT;
            nxt_swrw_cnt = SW'(`FX3_SWRW_WAIT);
            nxt_state    = STATE_WAIT_FLG_D;
         end
         STATE_WAIT_FLG_D: begin
            fx3_a = FX3_EP_OUT;
            if (out_empty)
               nxt_state = STATE_IDLE;
            else if (!out_almost_empty)
               nxt_state = STATE_READ;
            else if (swrw_cnt == SW'(1))
               nxt_state = STATE_SW_READ;
         end
         STATE_READ: begin
            fx3_a = FX3_EP_OUT;
            oe    = 1'b1;
            rd    = 1'b1;
            if (ingress_almost_full)
               nxt_state = STATE_READ_DRAIN_2;
            else if (out_almost_empty)
               nxt_state = STATE_READ_DRAIN_1;
         end
         STATE_SW_READ, STATE_READ_DRAIN_1: begin
            fx3_a     = FX3_EP_OUT;
            oe        = 1'b1;
            rd        = 1'b1;
            nxt_state = STATE_READ_DRAIN_2;
         end
         STATE_READ_DRAIN_2: begin
            fx3_a     = FX3_EP_OUT;
            oe        = 1'b1;
            nxt_state = STATE_READ_DRAIN_3;
         end
         STATE_READ_DRAIN_3: begin
            fx3_a     = FX3_EP_OUT;
            oe        = 1'b1;
            nxt_state = STATE_READ_DRAIN_4;
         end
         default: begin
            // Last drain cycle, words still in flight land here
            fx3_a     = FX3_EP_OUT;
            oe        = 1'b1;
            nxt_state = STATE_IDLE;
         end
      endcase
   end

   assign sloe_n   = ~oe;
   assign slrd_n   = ~rd;
   assign slwr_n   = ~wr;
   assign pktend_n = ~pktend;

   // Each write strobe takes the egress head in the same cycle
   assign egress_pop   = wr;
   assign ingress_push = rd_valid & ~out_empty;

endmodule

//--- rtl/fifo_sync_fwft.sv
`timescale 1ns/100ps
`include "fx3_consts.svh"

module fifo_sync_fwft #(
   parameter int DEPTH     = `FX3_BUFFER_DEPTH,
   parameter int AF_MARGIN = 0
) (
   input  logic                  clk_io_100,
   input  logic                  int_rst,
   input  logic [`FX3_WIDTH-1:0] din,
   input  logic                  wr_en,
   input  logic                  rd_en,
   output logic [`FX3_WIDTH-1:0] dout,
   output logic                  full,
   output logic                  empty,
   output logic                  almost_full
);

   localparam int AW = $clog2(DEPTH);
   localparam logic [AW:0] FULL_LVL = (AW+1)'(DEPTH);
   localparam logic [AW:0] AF_LVL = (AW+1)'(AF_MARGIN);

   logic [`FX3_WIDTH-1:0] mem [DEPTH];
   logic [AW-1:0]         wr_ptr;
   logic [AW-1:0]         rd_ptr;
   logic [AW:0]           count;
   logic                  do_wr;
   logic                  do_rd;

   // Writes to a full buffer and reads from an empty one are ignored
   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   always_ff @(posedge clk_io_100 or posedge int_rst) begin
      if (int_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr)
            wr_ptr <= wr_ptr + AW'(1);
         if (do_rd)
            rd_ptr <= rd_ptr + AW'(1);
         case ({do_wr, do_rd})
            2'b10: count <= count + (AW+1)'(1);
            2'b01: count <= count - (AW+1)'(1);
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk_io_100) begin
      if (do_wr)
         mem[wr_ptr] <= din;
   end

   // Head word shows without a read request
   assign dout        = mem[rd_ptr];
   assign full        = (count == FULL_LVL);
   assign empty       = (count == '0);
   assign almost_full = ((FULL_LVL - count) <= AF_LVL);

endmodule

//--- rtl/fx3_ctrl_pkg.sv
package fx3_ctrl_pkg;

   // Slave FIFO controller states
   typedef enum logic [3:0] {
      STATE_IDLE             = 4'd0,
      // Read path towards the out-endpoint
      STATE_FLG_C_RCVD       = 4'd1,
      STATE_WAIT_FLG_D       = 4'd2,
      STATE_READ             = 4'd3,
      STATE_READ_DRAIN_1     = 4'd4,
      STATE_READ_DRAIN_2     = 4'd5,
      STATE_READ_DRAIN_3     = 4'd6,
      STATE_READ_DRAIN_4     = 4'd7,
      // Write path towards the in-endpoint
      STATE_FLG_A_RCVD       = 4'd8,
      STATE_WAIT_FLG_B       = 4'd9,
      STATE_WRITE            = 4'd10,
      STATE_WRITE_FLUSH      = 4'd11,
      STATE_WAIT_FLG_A       = 4'd12,
      // Single word transfers after an almost-flag stall
      STATE_SW_READ          = 4'd13,
      STATE_SW_WRITE         = 4'd14,
      STATE_SW_WRITE_WAITFLG = 4'd15
   } fx3_state_e;

endpackage

//--- rtl/fx3_bus_pkg.sv
package fx3_bus_pkg;

   // Slave FIFO endpoint address on the fx3_a pins
   typedef enum logic [1:0] {
      // FPGA to host
      FX3_EP_IN  = 2'd0,
      // Host to FPGA
      FX3_EP_OUT = 2'd3
   } fx3_ep_e;

endpackage

//--- include/fx3_consts.svh
`ifndef FX3_CONSTS_SVH
`define FX3_CONSTS_SVH

// Width of one word on the FX3 data bus
`define FX3_WIDTH 16

// Words held by each of the ingress and egress buffers, power of two
`define FX3_BUFFER_DEPTH 16

// Idle cycles after the last write burst before a zero-length packet
`define FX3_FLUSH_TIMEOUT 64

// Cycles an almost flag may stall a burst before a single word transfer
`define FX3_SWRW_WAIT 15

// Ingress buffer reports almost full at or below this many free slots.
// Three words can still be in flight when reads stop, plus one spare
`define FX3_INGRESS_MARGIN 4

`endif
